// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_board
FILELIST  = compile.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
src/board_pkg.sv
src/key_debounce.sv
src/uart_rx.sv
src/uart_tx.sv
src/uart_control.sv
src/seg_display.sv
src/board_top.sv
verif/board_checker.sv
verif/tb_board.sv

// ==== src/board_pkg.sv ====
// board-wide timing defaults for a 50 MHz clock
// display nibble codes shared by the top level and the digit decoder
// UART receiver and transmitter state encodings
package board_pkg;

	// 50 MHz / 115200 baud
	localparam int clks_per_bit_default = 434;

	// 20 ms of stable level before a key change is accepted
	localparam int debounce_cycles_default = 1_000_000;

	// 1 ms per digit, so a full scan takes 8 ms
	localparam int scan_cycles_default = 50_000;

	// nibble codes for the display word
	// 0-9 and 12-14 show as hex glyphs
	localparam logic [3:0] code_blank = 4'd10;
	localparam logic [3:0] code_dash  = 4'd11;
	localparam logic [3:0] code_f     = 4'd15;

	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} uart_rx_state_t;

	typedef enum logic [1:0] {
		tx_idle,
		tx_start,
		tx_data,
		tx_stop
	} uart_tx_state_t;

endpackage

// ==== src/board_top.sv ====
// trainer board top level
// keys and LEDs, host UART with echo and count report, status display
`timescale 1ns/1ps

module board_top import board_pkg::*; #(
	parameter int clks_per_bit    = clks_per_bit_default,
	parameter int debounce_cycles = debounce_cycles_default,
	parameter int scan_cycles     = scan_cycles_default
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [3:0] key_in,
	output logic [7:0] led,
	output logic [7:0] seg_number,
	output logic [7:0] seg_choice,
	input  logic       uart_rx_port,
	output logic       uart_tx_port,
	output logic       uart_3v3_port,
	output logic       uart_gnd_port
);

	logic [3:0]  key_press;
	logic [7:0]  uart_rx_data;
	logic        uart_rx_valid;
	logic [7:0]  uart_tx_data;
	logic        uart_tx_start;
	logic        uart_tx_busy;
	logic [7:0]  last_byte;
	logic [7:0]  byte_count;
	logic [31:0] dsp_word;

	// supply pins for the host header
	assign uart_3v3_port = 1'b1;
	assign uart_gnd_port = 1'b0;

	// digit 7 down to digit 0: F, blank, dash, count, blank, last byte
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			dsp_word <= {code_f, {7{code_blank}}};
		end else begin
			dsp_word <= {code_f, code_blank, code_dash, byte_count[7:4], byte_count[3:0],
				code_blank, last_byte[7:4], last_byte[3:0]};
		end
	end

	key_debounce #(.debounce_cycles(debounce_cycles)) u_key_debounce (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.key_in    (key_in),
		.key_press (key_press),
		.led       (led)
	);

	uart_rx #(.clks_per_bit(clks_per_bit)) u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (uart_rx_port),
		.rx_data   (uart_rx_data),
		.rx_valid  (uart_rx_valid)
	);

	// key 0 asks for a count report
	uart_control u_uart_control (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.rx_data    (uart_rx_data),
		.rx_valid   (uart_rx_valid),
		.report_req (key_press[0]),
		.tx_busy    (uart_tx_busy),
		.tx_data    (uart_tx_data),
		.tx_start   (uart_tx_start),
		.last_byte  (last_byte),
		.byte_count (byte_count)
	);

	uart_tx #(.clks_per_bit(clks_per_bit)) u_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_data   (uart_tx_data),
		.tx_start  (uart_tx_start),
		.tx        (uart_tx_port),
		.tx_busy   (uart_tx_busy)
	);

	seg_display #(.scan_cycles(scan_cycles)) u_seg_display (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.seg_val    (dsp_word),
		.seg_number (seg_number),
		.seg_choice (seg_choice)
	);

endmodule

// ==== src/key_debounce.sv ====
// four-key debouncer for active-low push keys
// press pulses and one toggling LED per key
`timescale 1ns/1ps

module key_debounce import board_pkg::*; #(
	parameter int debounce_cycles = debounce_cycles_default
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [3:0] key_in,
	output logic [3:0] key_press,
	output logic [7:0] led
);

	localparam int cnt_w = $clog2(debounce_cycles + 1);

	// synchronizer stages inverted so 1 means pressed
	logic [3:0]       key_meta;
	logic [3:0]       key_sync;
	// accepted debounced level per key
	logic [3:0]       key_state;
	logic [cnt_w-1:0] stable_cnt [4];
	logic [3:0]       led_toggle;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			key_meta   <= '0;
			key_sync   <= '0;
			key_state  <= '0;
			key_press  <= '0;
			led_toggle <= '0;
			for (int i = 0; i < 4; i++) begin
				stable_cnt[i] <= '0;
			end
		end else begin
			key_meta  <= ~key_in;
			key_sync  <= key_meta;
			key_press <= '0;
			for (int i = 0; i < 4; i++) begin
				if (key_sync[i] == key_state[i]) begin
					// level agrees with the accepted state so the count restarts
					stable_cnt[i] <= '0;
				end else if (stable_cnt[i] == cnt_w'(debounce_cycles - 1)) begin
					stable_cnt[i] <= '0;
					key_state[i]  <= key_sync[i];
					// only the press edge counts while release stays silent
					if (key_sync[i]) begin
						key_press[i]  <= 1'b1;
						led_toggle[i] <= ~led_toggle[i];
					end
				end else begin
					stable_cnt[i] <= stable_cnt[i] + 1'b1;
				end
			end
		end
	end

	assign led = {key_state, led_toggle};

endmodule

// ==== src/seg_display.sv ====
// eight-digit scanner for a common-anode seven-segment display
// nibble to glyph decoder, segments and selects both active low
`timescale 1ns/1ps

module seg_display import board_pkg::*; #(
	parameter int scan_cycles = scan_cycles_default
) (
	input  logic        sys_clk,
	input  logic        sys_rst_n,
	input  logic [31:0] seg_val,
	output logic [7:0]  seg_number,
	output logic [7:0]  seg_choice
);

	localparam int cnt_w = $clog2(scan_cycles);

	logic [cnt_w-1:0] scan_cnt;
	logic [2:0]       digit_idx;
	logic [3:0]       nibble;
	logic [6:0]       glyph;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			scan_cnt  <= '0;
			digit_idx <= '0;
		end else if (scan_cnt == cnt_w'(scan_cycles - 1)) begin
			scan_cnt  <= '0;
			digit_idx <= digit_idx + 1'b1;
		end else begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

	assign nibble = seg_val[digit_idx*4 +: 4];

	// glyph bits are g down to a, 0 lights a segment
	always_comb begin
		case (nibble)
			4'd0:       glyph = 7'b100_0000;
			4'd1:       glyph = 7'b111_1001;
			4'd2:       glyph = 7'b010_0100;
			4'd3:       glyph = 7'b011_0000;
			4'd4:       glyph = 7'b001_1001;
			4'd5:       glyph = 7'b001_0010;
			4'd6:       glyph = 7'b000_0010;
			4'd7:       glyph = 7'b111_1000;
			4'd8:       glyph = 7'b000_0000;
			4'd9:       glyph = 7'b001_0000;
			code_blank: glyph = 7'b111_1111;
			code_dash:  glyph = 7'b011_1111;
			4'd12:      glyph = 7'b100_0110;
			4'd13:      glyph = 7'b010_0001;
			4'd14:      glyph = 7'b000_0110;
			code_f:     glyph = 7'b000_1110;
			default:    glyph = 7'b111_1111;
		endcase
	end

	// dp stays dark
	assign seg_number = {1'b1, glyph};
	assign seg_choice = ~(8'b0000_0001 << digit_idx);

endmodule

// ==== src/uart_control.sv ====
// byte counter, last received byte and echo of every byte
// key reports share the transmitter through a one-deep pending slot
`timescale 1ns/1ps

module uart_control (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [7:0] rx_data,
	input  logic       rx_valid,
	input  logic       report_req,
	input  logic       tx_busy,
	output logic [7:0] tx_data,
	output logic       tx_start,
	output logic [7:0] last_byte,
	output logic [7:0] byte_count
);

	logic       pend_valid;
	logic [7:0] pend_data;
	logic       can_send;

	// a start already on the wire has not raised busy yet
	assign can_send = !tx_busy && !tx_start;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			last_byte  <= '0;
			byte_count <= '0;
			tx_data    <= '0;
			tx_start   <= 1'b0;
			pend_valid <= 1'b0;
			pend_data  <= '0;
		end else begin
			tx_start <= 1'b0;
			if (rx_valid) begin
				last_byte  <= rx_data;
				byte_count <= byte_count + 1'b1;
			end

			if (can_send && pend_valid) begin
				tx_start   <= 1'b1;
				tx_data    <= pend_data;
				pend_valid <= 1'b0;
				// new arrivals refill the slot with echo first
				if (rx_valid) begin
					pend_valid <= 1'b1;
					pend_data  <= rx_data;
				end else if (report_req) begin
					pend_valid <= 1'b1;
					pend_data  <= byte_count;
				end
			end else if (can_send && rx_valid) begin
				tx_start <= 1'b1;
				tx_data  <= rx_data;
				if (report_req) begin
					pend_valid <= 1'b1;
					pend_data  <= byte_count;
				end
			end else if (can_send && report_req) begin
				tx_start <= 1'b1;
				tx_data  <= byte_count;
			end else if (rx_valid) begin
				// echo wins the slot over whatever waits there
				pend_valid <= 1'b1;
				pend_data  <= rx_data;
			end else if (report_req && !pend_valid) begin
				pend_valid <= 1'b1;
				pend_data  <= byte_count;
			end
		end
	end

endmodule

// ==== src/uart_rx.sv ====
// UART 8N1 receiver, one sample per bit taken at mid-bit
// start bit confirmed at half a bit, frames with a low stop bit are dropped
`timescale 1ns/1ps

module uart_rx import board_pkg::*; #(
	parameter int clks_per_bit = clks_per_bit_default
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       rx,
	output logic [7:0] rx_data,
	output logic       rx_valid
);

	localparam int cnt_w = $clog2(clks_per_bit);
	localparam int half_bit = clks_per_bit / 2;

	logic             rx_meta;
	logic             rx_sync;
	uart_rx_state_t   state;
	logic [cnt_w-1:0] cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shift;
	logic             bit_end;

	assign bit_end = (cnt == cnt_w'(clks_per_bit - 1));

	// control path
	// the port rx_data hides the enum literal, so that state is package-qualified
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta  <= 1'b1;
			rx_sync  <= 1'b1;
			state    <= rx_idle;
			cnt      <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_meta  <= rx;
			rx_sync  <= rx_meta;
			rx_valid <= 1'b0;
			case (state)
				rx_idle: begin
					cnt <= '0;
					if (!rx_sync) begin
						state <= rx_start;
					end
				end
				rx_start: begin
					if (cnt == cnt_w'(half_bit - 1)) begin
						cnt     <= '0;
						bit_idx <= '0;
						// a glitch shorter than half a bit is ignored
						state   <= rx_sync ? rx_idle : board_pkg::rx_data;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				board_pkg::rx_data: begin
					if (bit_end) begin
						cnt <= '0;
						if (bit_idx == 3'd7) begin
							state <= rx_stop;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin
					// mid stop bit, back to idle for the next falling edge
					if (bit_end) begin
						cnt      <= '0;
						state    <= rx_idle;
						rx_valid <= rx_sync;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// data path, LSB arrives first
	always_ff @(posedge sys_clk) begin
		if (state == board_pkg::rx_data && bit_end) begin
			shift <= {rx_sync, shift[7:1]};
		end
		if (state == rx_stop && bit_end && rx_sync) begin
			rx_data <= shift;
		end
	end

endmodule

// ==== src/uart_tx.sv ====
// UART 8N1 transmitter
// busy covers the start bit through the end of the stop bit
`timescale 1ns/1ps

module uart_tx import board_pkg::*; #(
	parameter int clks_per_bit = clks_per_bit_default
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [7:0] tx_data,
	input  logic       tx_start,
	output logic       tx,
	output logic       tx_busy
);

	localparam int cnt_w = $clog2(clks_per_bit);

	uart_tx_state_t   state;
	logic [cnt_w-1:0] cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shift;
	logic             bit_end;

	assign bit_end = (cnt == cnt_w'(clks_per_bit - 1));
	assign tx_busy = (state != tx_idle);

	// ports tx_start and tx_data hide the enum literals of the same names
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= tx_idle;
			cnt     <= '0;
			bit_idx <= '0;
			tx      <= 1'b1;
		end else begin
			case (state)
				tx_idle: begin
					cnt <= '0;
					if (tx_start) begin
						// line goes low on the next cycle
						tx    <= 1'b0;
						state <= board_pkg::tx_start;
					end
				end
				board_pkg::tx_start: begin
					if (bit_end) begin
						cnt     <= '0;
						bit_idx <= '0;
						tx      <= shift[0];
						state   <= board_pkg::tx_data;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				board_pkg::tx_data: begin
					if (bit_end) begin
						cnt <= '0;
						if (bit_idx == 3'd7) begin
							tx    <= 1'b1;
							state <= tx_stop;
						end else begin
							bit_idx <= bit_idx + 1'b1;
							// shift moves on this same edge
							tx      <= shift[1];
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin
					if (bit_end) begin
						cnt   <= '0;
						state <= tx_idle;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == tx_idle && tx_start) begin
			shift <= tx_data;
		end else if (state == board_pkg::tx_data && bit_end) begin
			shift <= {1'b0, shift[7:1]};
		end
	end

endmodule

// ==== verif/board_checker.sv ====
// bound assertions on board_top
// display select, UART line idle level and transmit handshake
`timescale 1ns/1ps

module board_checker (
	input logic       sys_clk,
	input logic       sys_rst_n,
	input logic [7:0] seg_choice,
	input logic       uart_tx_port,
	input logic       tx_busy,
	input logic       tx_start,
	input logic       rx_valid
);

	// one digit lit at a time
	a_one_digit: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$onehot(~seg_choice))
		else $error("seg_choice does not have exactly one active select");

	// idle line stays at the mark level
	a_idle_high: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!tx_busy |-> uart_tx_port)
		else $error("uart_tx_port low while the transmitter is idle");

	a_start_not_busy: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_start |-> !tx_busy)
		else $error("tx_start raised while the transmitter is busy");

	// receiver pulse is a single cycle
	a_valid_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_valid |=> !rx_valid)
		else $error("rx_valid high for two cycles in a row");

endmodule

bind board_top board_checker u_board_checker (
	.sys_clk      (sys_clk),
	.sys_rst_n    (sys_rst_n),
	.seg_choice   (seg_choice),
	.uart_tx_port (uart_tx_port),
	.tx_busy      (uart_tx_busy),
	.tx_start     (uart_tx_start),
	.rx_valid     (uart_rx_valid)
);

// ==== verif/tb_board.sv ====
// testbench for board_top with shortened timing
// LCG stimulus, UART host model, key presses with bounce, display sampling
`timescale 1ns/1ps

module tb_board;

	localparam int bit_cycles   = 16;
	localparam int debounce_len = 32;
	localparam int scan_len     = 8;
	localparam int num_bytes    = 20;
	localparam int byte_wait_cycles = 3 * 10 * bit_cycles;
	// step budgets cover frames out and back, one display scan and key press and release
	localparam int byte_step_cycles = 2 * 12 * bit_cycles + 8 * scan_len + 32;
	localparam int key_step_cycles  = 12 * bit_cycles + 6 * debounce_len + 64;
	localparam int watchdog_cycles  = (num_bytes + 1) * byte_step_cycles
		+ (num_bytes / 5 + 2) * key_step_cycles + 2000;

	logic       sys_clk;
	logic       sys_rst_n;
	logic [3:0] key_in;
	logic [7:0] led;
	logic [7:0] seg_number;
	logic [7:0] seg_choice;
	logic       uart_rx_port;
	logic       uart_tx_port;
	logic       uart_3v3_port;
	logic       uart_gnd_port;

	logic [31:0] lcg_state = 32'hbc5e_435d;
	logic [7:0]  tx_q [$];
	logic [7:0]  exp_count;
	logic [7:0]  exp_last;
	int          error_count = 0;
	int          check_count = 0;

	board_top #(
		.clks_per_bit    (bit_cycles),
		.debounce_cycles (debounce_len),
		.scan_cycles     (scan_len)
	) dut (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.key_in        (key_in),
		.led           (led),
		.seg_number    (seg_number),
		.seg_choice    (seg_choice),
		.uart_rx_port  (uart_rx_port),
		.uart_tx_port  (uart_tx_port),
		.uart_3v3_port (uart_3v3_port),
		.uart_gnd_port (uart_gnd_port)
	);

	always #10 sys_clk = ~sys_clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int unsigned rand_below(input int unsigned n);
		return (lcg_next() >> 16) % n;
	endfunction

	// active-low a-g with dp off for each display nibble code
	function automatic logic [7:0] glyph_of(input logic [3:0] n);
		case (n)
			4'h0: return 8'hc0;
			4'h1: return 8'hf9;
			4'h2: return 8'ha4;
			4'h3: return 8'hb0;
			4'h4: return 8'h99;
			4'h5: return 8'h92;
			4'h6: return 8'h82;
			4'h7: return 8'hf8;
			4'h8: return 8'h80;
			4'h9: return 8'h90;
			4'ha: return 8'hff;
			4'hb: return 8'hbf;
			4'hc: return 8'hc6;
			4'hd: return 8'ha1;
			4'he: return 8'h86;
			default: return 8'h8e;
		endcase
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, expected);
		end
	endtask

	// host side of the link sending 8N1 LSB first
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge sys_clk);
			uart_rx_port <= frame[i];
			repeat (bit_cycles - 1) @(posedge sys_clk);
		end
	endtask

	task automatic expect_tx_byte(input string what, input logic [7:0] expected);
		int         waited;
		logic [7:0] got;
		waited = 0;
		while (tx_q.size() == 0 && waited < byte_wait_cycles) begin
			@(negedge sys_clk);
			waited++;
		end
		if (tx_q.size() == 0) begin
			error_count++;
			$display("no %s byte appeared on uart_tx_port within %0d cycles",
				what, byte_wait_cycles);
		end else begin
			got = tx_q.pop_front();
			check_value(what, got, expected);
		end
	endtask

	// one full scan keeping the last segments seen per digit
	task automatic check_display();
		logic [7:0] seen [8];
		logic [3:0] nib [8];
		nib[7] = 4'hf;
		nib[6] = 4'ha;
		nib[5] = 4'hb;
		nib[4] = exp_count[7:4];
		nib[3] = exp_count[3:0];
		nib[2] = 4'ha;
		nib[1] = exp_last[7:4];
		nib[0] = exp_last[3:0];
		for (int d = 0; d < 8; d++) begin
			seen[d] = 'x;
		end
		repeat (8 * scan_len + 2) begin
			@(negedge sys_clk);
			for (int d = 0; d < 8; d++) begin
				if (seg_choice[d] == 1'b0) begin
					seen[d] = seg_number;
				end
			end
		end
		for (int d = 0; d < 8; d++) begin
			check_value($sformatf("digit %0d segments", d), seen[d], glyph_of(nib[d]));
		end
	endtask

	task automatic press_key(input int k, input bit bounce);
		logic [7:0] led_before;
		logic [3:0] led_after;
		logic       prev;
		int         toggles;
		int         glitches;
		int         len;
		@(negedge sys_clk);
		led_before = led;
		led_after  = led_before[3:0] ^ (4'b0001 << k);
		if (bounce) begin
			glitches = 1 + rand_below(3);
			for (int g = 0; g < glitches; g++) begin
				len = 1 + rand_below(debounce_len / 2);
				@(posedge sys_clk);
				key_in[k] <= 1'b0;
				repeat (len) @(posedge sys_clk);
				key_in[k] <= 1'b1;
				repeat (4) @(posedge sys_clk);
			end
			repeat (debounce_len) @(posedge sys_clk);
			@(negedge sys_clk);
			check_value($sformatf("led after bounce on key %0d", k), led, led_before);
		end
		// clean press held past the debounce time
		@(posedge sys_clk);
		key_in[k] <= 1'b0;
		prev    = led_before[k];
		toggles = 0;
		repeat (debounce_len + 8) begin
			@(negedge sys_clk);
			if (led[k] !== prev) begin
				toggles++;
				prev = led[k];
			end
		end
		check_value($sformatf("toggles of key %0d", k), toggles, 1);
		check_value($sformatf("held level of key %0d", k), led[4 + k], 1'b1);
		check_value($sformatf("toggle leds after key %0d", k), led[3:0], led_after);
		@(posedge sys_clk);
		key_in[k] <= 1'b1;
		repeat (debounce_len + 8) @(negedge sys_clk);
		check_value($sformatf("led after release of key %0d", k), led, {4'b0, led_after});
	endtask

	// decodes the DUT transmit line at mid-bit
	initial begin
		logic [7:0] b;
		@(posedge sys_rst_n);
		forever begin
			@(negedge sys_clk);
			if (uart_tx_port === 1'b0) begin
				repeat (bit_cycles / 2) @(negedge sys_clk);
				for (int i = 0; i < 8; i++) begin
					repeat (bit_cycles) @(negedge sys_clk);
					b[i] = uart_tx_port;
				end
				repeat (bit_cycles) @(negedge sys_clk);
				if (uart_tx_port !== 1'b1) begin
					error_count++;
					$display("frame on uart_tx_port at %0t has a low stop bit", $time);
				end
				tx_q.push_back(b);
			end
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge sys_clk);
		$display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
		$display("checks run: %0d, errors: %0d", check_count, error_count + 1);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		logic [7:0] b;
		int         k;
		sys_clk      = 1'b0;
		sys_rst_n    = 1'b0;
		key_in       = 4'hf;
		uart_rx_port = 1'b1;
		exp_count    = '0;
		exp_last     = '0;
		repeat (10) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		repeat (2) @(negedge sys_clk);
		check_value("uart_tx_port after reset", uart_tx_port, 1'b1);
		check_value("led after reset", led, 8'h00);
		check_value("uart_3v3_port", uart_3v3_port, 1'b1);
		check_value("uart_gnd_port", uart_gnd_port, 1'b0);

		for (int n = 0; n < num_bytes; n++) begin
			b = 8'(lcg_next() >> 24);
			send_byte(b);
			exp_count = exp_count + 8'd1;
			exp_last  = b;
			expect_tx_byte("echo", b);
			check_display();
			repeat (rand_below(16)) @(posedge sys_clk);
			if (n % 5 == 4) begin
				k = rand_below(4);
				press_key(k, 1'b1);
				if (k == 0) begin
					expect_tx_byte("count report", exp_count);
				end
			end
		end

		press_key(0, 1'b1);
		expect_tx_byte("count report", exp_count);

		// report requested while the echo is still on the wire
		b = 8'(lcg_next() >> 24);
		send_byte(b);
		exp_count = exp_count + 8'd1;
		exp_last  = b;
		press_key(0, 1'b0);
		expect_tx_byte("echo before report", b);
		expect_tx_byte("count report after echo", exp_count);

		repeat (2 * 10 * bit_cycles) @(negedge sys_clk);
		check_value("unexpected bytes left", tx_q.size(), 0);

		$display("checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
